// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_usb_sie
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_clock.sv
// Clock and reset source for the USB engine testbench, instantiated by the testbench top
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 8
)
(
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk); // Three cycles in reset
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// File: dv/tb_usb_sie.sv
// Testbench of the USB engine that models the transceiver and processor bus and checks replies
`timescale 1ns/1ps

module tb_usb_sie import usb_sie_pkg::*; ();

	typedef logic [7:0] byte_q_t [$];

	localparam int MAX_PACKET   = 8;
	localparam int RESP_TIMEOUT = 300; // Cycles allowed for a whole reply

	logic        clk;
	logic        arst_n;
	usb_rx_t     rx;
	logic        tx_ready;
	io_addr_t    io_addr;
	logic        io_rd;
	logic        io_wr;
	logic [15:0] io_dout;
	usb_tx_t     tx;
	logic [15:0] io_din;
	byte_q_t     tx_q; // Bytes accepted by the transceiver model
	integer      seed = 96;

	tb_clock i_clock (.clk(clk), .arst_n(arst_n));

	usb_sie_top #(.FIFO_DEPTH(64), .MAX_PACKET(MAX_PACKET)) i_dut (
		.clk(clk), .arst_n(arst_n), .rx(rx), .tx_ready(tx_ready), .io_addr(io_addr),
		.io_rd(io_rd), .io_wr(io_wr), .io_dout(io_dout), .tx(tx), .io_din(io_din));

	function automatic logic [7:0] pid_byte(input pid_t pid);
		return {~pid, pid};
	endfunction

	// USB CRC16 with bytes entering LSB first into a reflected register preset to ones
	function automatic logic [15:0] ref_crc16(input byte_q_t bytes);
		logic [15:0] c;
		logic        fb;
		c = 16'hFFFF;
		foreach (bytes[k])
		begin
			for (int i = 0; i < 8; i++)
			begin
				fb = c[0] ^ bytes[k][i];
				c  = c >> 1;
				if (fb)
					c = c ^ 16'hA001;
			end
		end
		return c;
	endfunction

	function automatic logic [7:0] bit_reverse(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = b[7 - i];
		return r;
	endfunction

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Replies only start once the received packet is over
	a_no_tx_during_rx: assert property (@(posedge clk) disable iff (!arst_n)
		rx.rx_active |-> !tx.tx_valid)
		else
		begin
			$display("CHECK FAILED at %0t ns: tx_valid = 1, expected 0 during rx_active", $time);
			abort_run();
		end

	// Transceiver transmit side picks tx_ready and records the byte the next edge takes
	initial
	begin
		tx_ready = 1'b0;
		forever
		begin
			@(negedge clk);
			tx_ready = ($random(seed) % 4) != 0;
			if (arst_n && tx.tx_valid && tx_ready)
				tx_q.push_back(tx.tx_data);
		end
	end

	task automatic send_packet(input byte_q_t bytes);
		@(negedge clk);
		rx.rx_active = 1'b1;
		foreach (bytes[k])
		begin
			repeat (2) @(negedge clk); // Byte gap of the bit stream
			rx.rx_data  = bytes[k];
			rx.rx_valid = 1'b1;
			@(negedge clk);
			rx.rx_valid = 1'b0;
		end
		repeat (2) @(negedge clk);
		rx.rx_active = 1'b0;
	endtask

	task automatic send_token(input pid_t pid, input logic [3:0] ep);
		byte_q_t b;
		b.push_back(pid_byte(pid));
		b.push_back({ep[0], 7'h2A}); // Any address is accepted
		b.push_back({5'h00, ep[3:1]});
		send_packet(b);
	endtask

	task automatic send_data(input pid_t pid, input byte_q_t payload, input logic bad_crc);
		byte_q_t     b;
		logic [15:0] c;
		c = ref_crc16(payload);
		b.push_back(pid_byte(pid));
		foreach (payload[k])
			b.push_back(payload[k]);
		b.push_back(~c[7:0]);
		b.push_back(~c[15:8] ^ {7'b0, bad_crc});
		send_packet(b);
	endtask

	task automatic io_write(input io_addr_t addr, input logic [15:0] data);
		@(negedge clk);
		io_addr = addr;
		io_dout = data;
		io_wr   = 1'b1;
		@(negedge clk);
		io_wr = 1'b0;
	endtask

	task automatic io_read(input io_addr_t addr, output logic [15:0] data);
		@(negedge clk);
		io_addr = addr;
		io_rd   = 1'b1;
		@(negedge clk);
		data  = io_din; // Reads have no side effect
		io_rd = 1'b0;
	endtask

	task automatic load_in_fifo(input io_addr_t addr, input int n, input int base,
		output byte_q_t bytes);
		bytes.delete();
		for (int i = 0; i < n; i++)
		begin
			bytes.push_back(8'(base + i * 37));
			io_write(addr, {8'h00, bytes[i]});
		end
	endtask

	task automatic expect_packet(input byte_q_t exp);
		int waited;
		waited = 0;
		while (tx_q.size() < exp.size())
		begin
			if (waited == RESP_TIMEOUT)
			begin
				$display("Timeout waiting for a %0d-byte reply, only %0d bytes arrived",
					exp.size(), tx_q.size());
				abort_run();
			end
			waited++;
			@(negedge clk);
		end
		repeat (4) @(negedge clk); // Catch trailing bytes
		check_value("tx byte count", 16'(tx_q.size()), 16'(exp.size()));
		foreach (exp[k])
			check_value($sformatf("tx_data[%0d]", k), {8'h00, tx_q[k]}, {8'h00, exp[k]});
		tx_q.delete();
	endtask

	task automatic expect_handshake(input logic [7:0] pid_b);
		byte_q_t exp;
		exp.push_back(pid_b);
		exp.push_back(8'h00);
		expect_packet(exp);
	endtask

	task automatic expect_data(input byte_q_t payload);
		byte_q_t     exp;
		logic [15:0] c;
		c = ref_crc16(payload);
		exp.push_back(8'hC3);
		foreach (payload[k])
			exp.push_back(payload[k]);
		exp.push_back(bit_reverse(~c[7:0])); // CRC goes out inverted and reversed
		exp.push_back(bit_reverse(~c[15:8]));
		exp.push_back(8'h00);
		expect_packet(exp);
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			check_value("tx_valid", 16'(tx.tx_valid), 16'h0000);
		end
		tx_q.delete();
	endtask

	// Pops every byte of the out-FIFO and expects it empty afterwards
	task automatic drain_out_fifo(input byte_q_t exp);
		logic [15:0] rd;
		foreach (exp[k])
		begin
			io_read(ENDPO0_DATA, rd);
			check_value($sformatf("io_din out byte %0d", k), rd, {8'h00, exp[k]});
			io_write(ENDPO0_CONTROL, 16'h0002);
		end
		io_read(ENDPO0_CONTROL, rd);
		check_value("io_din out empty", rd, 16'h0001);
	endtask

	initial
	begin
		byte_q_t     payload;
		byte_q_t     first;
		byte_q_t     rest;
		byte_q_t     stored;
		logic [15:0] c;
		int          waited;

		rx      = '0;
		io_addr = ENDPI0_DATA;
		io_rd   = 1'b0;
		io_wr   = 1'b0;
		io_dout = 16'h0000;

		waited = 0;
		while (!arst_n)
		begin
			if (waited == 20)
			begin
				$display("Reset was never released");
				abort_run();
			end
			waited++;
			@(negedge clk);
		end
		repeat (2) @(negedge clk);

		send_token(IN, 4'd0); // Empty endpoint answers NAK
		expect_handshake(8'h5A);

		io_write(ENDPI1_CONTROL, 16'h0002);
		send_token(IN, 4'd1);
		expect_handshake(8'h1E);
		send_token(IN, 4'd1); // Stall bit cleared by the STALL
		expect_handshake(8'h5A);

		load_in_fifo(ENDPI0_DATA, 5, 8'h11, payload);
		send_token(IN, 4'd0);
		expect_data(payload);

		load_in_fifo(ENDPI1_DATA, 12, 8'h40, payload);
		foreach (payload[k])
		begin
			if (k < MAX_PACKET)
				first.push_back(payload[k]);
			else
				rest.push_back(payload[k]);
		end
		send_token(IN, 4'd1);
		expect_data(first);
		send_token(IN, 4'd1); // Leftover bytes
		expect_data(rest);

		payload.delete();
		for (int i = 0; i < 6; i++)
			payload.push_back(8'(8'hA0 + i * 13));
		c = ref_crc16(payload);
		send_token(OUT, 4'd0);
		send_data(DATA0, payload, 1'b0);
		expect_handshake(8'hD2);
		stored = payload;
		stored.push_back(~c[7:0]); // CRC bytes are stored too
		stored.push_back(~c[15:8]);
		drain_out_fifo(stored);

		send_token(OUT, 4'd0);
		send_data(DATA0, payload, 1'b1);
		expect_quiet(40);
		stored[stored.size() - 1] = ~c[15:8] ^ 8'h01;
		drain_out_fifo(stored);

		send_token(SETUP, 4'd0); // SETUP accepts only DATA0
		send_data(DATA1, payload, 1'b0);
		expect_quiet(40);
		stored.delete();
		drain_out_fifo(stored);

		$display("All tests passed");
		$finish;
	end

endmodule

// File: src/usb_crc16.sv
// CRC16 engine for USB data packets, stepped one byte at a time by the packet FSM
`timescale 1ns/1ps

module usb_crc16 import usb_sie_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        clear,
	input  logic        step,
	input  logic [7:0]  data,
	output logic [15:0] crc,
	output logic        ok
);

	// Shifts one byte through the register, bit 0 first
	function automatic logic [15:0] crc_next(input logic [15:0] c, input logic [7:0] d);
		logic [15:0] r;
		r = c;
		for (int i = 0; i < 8; i++)
		begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ CRC16_POLY;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			crc <= 16'hFFFF;
		else if (clear)
			crc <= 16'hFFFF; // Preset for the next packet
		else if (step)
			crc <= crc_next(crc, data);
	end

	// Residual after data and CRC bytes of a good packet
	assign ok = (crc == CRC16_RESIDUAL);

endmodule

// File: src/usb_endpoint_fifo.sv
// Byte FIFO of one endpoint, head byte always visible on q
`timescale 1ns/1ps

module usb_endpoint_fifo #(
	parameter int FIFO_DEPTH = 64
)
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       sclr,
	input  logic [7:0] data,
	input  logic       wrreq,
	input  logic       rdreq,
	output logic [7:0] q,
	output logic       empty,
	output logic       full
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	logic [7:0]    mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] level;
	logic          do_wr;
	logic          do_rd;

	assign do_wr = wrreq && !full;
	assign do_rd = rdreq && !empty;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else if (sclr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				level <= level + 1'b1;
			else if (do_rd && !do_wr)
				level <= level - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr && !sclr)
			mem[wr_ptr] <= data;
	end

	assign q     = mem[rd_ptr]; // Read-ahead
	assign empty = (level == '0);
	assign full  = (level == CW'(FIFO_DEPTH));

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		wrreq && !sclr |-> !full)
		else $error("write to full endpoint FIFO");

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		rdreq && !sclr |-> !empty)
		else $error("read from empty endpoint FIFO");

endmodule

// File: src/usb_endpoint_regs.sv
// Endpoint FIFOs, stall bits and processor register decode, selected by token endpoint
`timescale 1ns/1ps

module usb_endpoint_regs import usb_sie_pkg::*; #(
	parameter int FIFO_DEPTH = 64
)
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        usb_reset,
	input  logic [3:0]  endp,
	input  logic        in_rdreq,
	input  logic        out_wrreq,
	input  logic [7:0]  out_data,
	input  logic        stall_sent,
	input  io_addr_t    io_addr,
	input  logic        io_rd,
	input  logic        io_wr,
	input  logic [15:0] io_dout,
	output logic [15:0] io_din,
	output logic        sel_empty,
	output logic        sel_full,
	output logic        sel_stall,
	output logic [7:0]  sel_q
);

	typedef struct packed
	{
		logic [7:0] q;
		logic       empty;
		logic       full;
	} fifo_st_t;

	fifo_st_t   pi0;
	fifo_st_t   pi1;
	fifo_st_t   po0;
	logic [1:0] stall; // Per IN endpoint
	logic       pop_out;

	assign pop_out = io_wr && (io_addr == ENDPO0_CONTROL) && io_dout[1];

	usb_endpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_endpi0 (
		.clk(clk), .arst_n(arst_n), .sclr(usb_reset), .data(io_dout[7:0]),
		.wrreq(io_wr && (io_addr == ENDPI0_DATA)), .rdreq(in_rdreq && (endp == 4'd0)),
		.q(pi0.q), .empty(pi0.empty), .full(pi0.full));

	usb_endpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_endpi1 (
		.clk(clk), .arst_n(arst_n), .sclr(usb_reset), .data(io_dout[7:0]),
		.wrreq(io_wr && (io_addr == ENDPI1_DATA)), .rdreq(in_rdreq && (endp == 4'd1)),
		.q(pi1.q), .empty(pi1.empty), .full(pi1.full));

	// OUT data and its two CRC bytes land here
	usb_endpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_endpo0 (
		.clk(clk), .arst_n(arst_n), .sclr(usb_reset), .data(out_data),
		.wrreq(out_wrreq && (endp == 4'd0)), .rdreq(pop_out),
		.q(po0.q), .empty(po0.empty), .full(po0.full));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			stall <= 2'b00;
		else if (usb_reset)
			stall <= 2'b00;
		else
		begin
			if (stall_sent && (endp == 4'd0))
				stall[0] <= 1'b0;
			if (stall_sent && (endp == 4'd1))
				stall[1] <= 1'b0;
			if (io_wr && (io_addr == ENDPI0_CONTROL))
				stall[0] <= io_dout[1]; // Processor write wins
			if (io_wr && (io_addr == ENDPI1_CONTROL))
				stall[1] <= io_dout[1];
		end
	end

	always_comb
	begin
		sel_empty = 1'b1; // Missing endpoints
		sel_full  = 1'b1;
		sel_stall = 1'b0;
		sel_q     = 8'h00;
		case (endp)
			4'd0:
			begin
				sel_empty = pi0.empty;
				sel_full  = po0.full;
				sel_stall = stall[0];
				sel_q     = pi0.q;
			end
			4'd1:
			begin
				sel_empty = pi1.empty;
				sel_stall = stall[1];
				sel_q     = pi1.q;
			end
			default: ;
		endcase
	end

	// Zero when idle since the bus is OR-combined
	always_comb
	begin
		io_din = 16'h0000;
		if (io_rd)
		begin
			case (io_addr)
				ENDPI0_CONTROL: io_din[0]   = pi0.full;
				ENDPI1_CONTROL: io_din[0]   = pi1.full;
				ENDPO0_CONTROL: io_din[0]   = po0.empty;
				ENDPO0_DATA:    io_din[7:0] = po0.q;
				default: ;
			endcase
		end
	end

endmodule

// File: src/usb_packet_fsm.sv
// Packet FSM of the USB engine, decodes tokens and sequences data and handshake packets
`timescale 1ns/1ps

module usb_packet_fsm import usb_sie_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  usb_rx_t     rx,
	input  logic        tx_ready,
	input  logic        sel_empty,
	input  logic        sel_full,
	input  logic        sel_stall,
	input  logic [7:0]  sel_q,
	input  logic [15:0] crc,
	input  logic        crc_ok,
	input  logic        len_max,
	output usb_tx_t     tx,
	output logic [3:0]  endp,
	output logic        in_rdreq,
	output logic        out_wrreq,
	output logic [7:0]  out_data,
	output logic        stall_sent,
	output logic        crc_clear,
	output logic        crc_step,
	output logic [7:0]  crc_byte,
	output logic        len_clear,
	output logic        len_step
);

	typedef enum logic [3:0]
	{
		S_TOKEN0, S_TOKEN1, S_TOKEN2,
		S_DATA_OUT0, S_DATA_OUT1,
		S_DATA_IN0, S_DATA_IN1, S_DATA_IN2, S_DATA_IN3, S_DATA_IN4, S_DATA_IN5,
		S_ACK, S_NAK, S_STALL, S_LAST_BIT
	} state_t;

	state_t     state;
	state_t     state_next;
	token_t     token;
	logic       pkt_start;  // Next byte is a PID
	pid_t       rx_pid;
	logic [3:0] setup_endp; // Endpoint while its last bits arrive

	assign rx_pid     = pid_t'(rx.rx_data[3:0]);
	assign setup_endp = {rx.rx_data[2:0], token.endp[0]};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= S_TOKEN0;
		else if (rx.usb_reset)
			state <= S_TOKEN0;
		else
			state <= state_next;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pkt_start <= 1'b1;
		else if (!rx.rx_active)
			pkt_start <= 1'b1;
		else if (rx.rx_valid)
			pkt_start <= 1'b0;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			token <= '0;
		else if (rx.usb_reset)
			token <= '0;
		else if (rx.rx_valid)
		begin
			case (state)
				S_TOKEN0:
				begin
					token.pid  <= rx_pid;
					token.pidx <= rx.rx_data[7:4];
				end
				S_TOKEN1:
				begin
					token.addr    <= rx.rx_data[6:0];
					token.endp[0] <= rx.rx_data[7];
				end
				S_TOKEN2:
				begin
					token.endp[3:1] <= rx.rx_data[2:0];
					token.crc5      <= rx.rx_data[7:3];
				end
				default: ;
			endcase
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			S_TOKEN0:
				if (rx.rx_valid && pkt_start && (rx_pid inside {OUT, IN, SETUP}))
					state_next = S_TOKEN1;
			S_TOKEN1:
				if (rx.rx_valid)
					state_next = S_TOKEN2;
				else if (!rx.rx_active)
					state_next = S_TOKEN0; // Short token
			S_TOKEN2:
				if (rx.rx_valid)
				begin
					if (token.pid == OUT || (token.pid == SETUP && setup_endp == 4'd0))
						state_next = S_DATA_OUT0;
					else if (token.pid == SETUP)
						state_next = S_TOKEN0;
				end
				else if (!rx.rx_active)
				begin
					if (token.pid != IN)
						state_next = S_TOKEN0;
					else if (sel_stall)
						state_next = S_STALL;
					else if (sel_empty)
						state_next = S_NAK;
					else
						state_next = S_DATA_IN0;
				end
			S_DATA_OUT0:
				if (rx.rx_valid)
				begin
					if (!sel_full && (rx_pid == DATA0 || (rx_pid == DATA1 && token.pid != SETUP)))
						state_next = S_DATA_OUT1;
					else
						state_next = S_TOKEN0;
				end
			S_DATA_OUT1:
				if (rx.rx_valid && sel_full)
					state_next = S_TOKEN0; // Drop without handshake
				else if (!rx.rx_active)
					state_next = crc_ok ? S_ACK : S_TOKEN0;
			S_DATA_IN0:
				if (tx_ready)
					state_next = S_DATA_IN1;
			S_DATA_IN1:
				if (tx_ready)
					state_next = S_DATA_IN2;
			S_DATA_IN2:
				state_next = (!sel_empty && !len_max) ? S_DATA_IN1 : S_DATA_IN3;
			S_DATA_IN3:
				if (tx_ready)
					state_next = S_DATA_IN4;
			S_DATA_IN4:
				if (tx_ready)
					state_next = S_DATA_IN5;
			S_ACK, S_NAK, S_STALL:
				if (tx_ready)
					state_next = S_LAST_BIT;
			S_DATA_IN5, S_LAST_BIT:
				if (tx_ready)
					state_next = S_TOKEN0;
			default:
				state_next = S_TOKEN0;
		endcase
	end

	always_comb
	begin
		tx         = '0; // Data zero when idle
		in_rdreq   = 1'b0;
		out_wrreq  = 1'b0;
		stall_sent = 1'b0;
		crc_step   = 1'b0;
		crc_byte   = rx.rx_data;
		len_step   = 1'b0;
		case (state)
			S_DATA_OUT1:
			begin
				out_wrreq = rx.rx_valid && !sel_full;
				crc_step  = rx.rx_valid;
			end
			S_DATA_IN0:
			begin
				tx.tx_valid = 1'b1;
				tx.tx_data  = {~DATA0, DATA0};
			end
			S_DATA_IN1:
			begin
				tx.tx_valid = 1'b1;
				tx.tx_data  = sel_q;
				crc_byte    = sel_q;
				in_rdreq    = tx_ready;
				crc_step    = tx_ready;
				len_step    = tx_ready;
			end
			S_DATA_IN3:
			begin
				tx.tx_valid = 1'b1;
				for (int i = 0; i < 8; i++)
					tx.tx_data[i] = ~crc[7-i];
			end
			S_DATA_IN4:
			begin
				tx.tx_valid = 1'b1;
				for (int i = 0; i < 8; i++)
					tx.tx_data[i] = ~crc[15-i];
			end
			S_ACK:
			begin
				tx.tx_valid = 1'b1;
				tx.tx_data  = {~ACK, ACK};
			end
			S_NAK:
			begin
				tx.tx_valid = 1'b1;
				tx.tx_data  = {~NAK, NAK};
			end
			S_STALL:
			begin
				tx.tx_valid = 1'b1;
				tx.tx_data  = {~STALL, STALL};
				stall_sent  = tx_ready;
			end
			S_DATA_IN5, S_LAST_BIT:
				tx.tx_valid = 1'b1; // End of packet
			default: ;
		endcase
	end

	assign endp      = token.endp;
	assign out_data  = rx.rx_data;
	assign crc_clear = rx.usb_reset || state == S_DATA_OUT0 || state == S_DATA_IN0;
	assign len_clear = rx.usb_reset || state == S_DATA_IN0;

	a_tx_hold: assert property (@(posedge clk) disable iff (!arst_n || rx.usb_reset)
		tx.tx_valid && !tx_ready |=> tx.tx_valid && $stable(tx.tx_data))
		else $error("tx byte changed under back-pressure");

endmodule

// File: src/usb_packet_len.sv
// Byte counter for an IN data packet, flags when the maximum packet size is reached
`timescale 1ns/1ps

module usb_packet_len #(
	parameter int MAX_PACKET = 8
)
(
	input  logic clk,
	input  logic arst_n,
	input  logic clear,
	input  logic step,
	output logic len_max
);

	localparam int CW = $clog2(MAX_PACKET + 1);

	logic [CW-1:0] count; // Bytes sent so far

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			count <= '0;
		else if (clear)
			count <= '0;
		else if (step)
			count <= count + 1'b1;
	end

	assign len_max = (count == CW'(MAX_PACKET));

	// The FSM must close the packet before another payload byte
	a_no_step_at_max: assert property (@(posedge clk) disable iff (!arst_n)
		step && !clear |-> !len_max)
		else $error("payload byte sent beyond MAX_PACKET");

endmodule

// File: src/usb_sie_pkg.sv
// Shared USB engine types and constants, imported by the RTL blocks and the testbench
package usb_sie_pkg;

	// Packet identifiers, low nibble of the PID byte
	typedef enum logic [3:0]
	{
		RESERVED = 4'b0000,
		OUT      = 4'b0001,
		IN       = 4'b1001,
		SETUP    = 4'b1101,
		DATA0    = 4'b0011,
		DATA1    = 4'b1011,
		ACK      = 4'b0010,
		NAK      = 4'b1010,
		STALL    = 4'b1110
	} pid_t;

	// Token fields, LSB first as on the wire
	typedef struct packed
	{
		logic [4:0] crc5;
		logic [3:0] endp;
		logic [6:0] addr;
		logic [3:0] pidx; // Complement of pid
		pid_t       pid;
	} token_t;

	typedef struct packed
	{
		logic [7:0] rx_data;
		logic       rx_valid;  // One cycle per byte
		logic       rx_active; // High for a whole packet
		logic       usb_reset; // Bus reset level
	} usb_rx_t;

	typedef struct packed
	{
		logic [7:0] tx_data;
		logic       tx_valid;
	} usb_tx_t;

	// Processor I/O register map
	typedef enum logic [3:0]
	{
		ENDPI0_DATA    = 4'h0,
		ENDPI0_CONTROL = 4'h1,
		ENDPI1_DATA    = 4'h2,
		ENDPI1_CONTROL = 4'h3,
		ENDPO0_DATA    = 4'h4,
		ENDPO0_CONTROL = 4'h5
	} io_addr_t;

	// x^16 + x^15 + x^2 + 1, reflected since the LSB goes first
	localparam logic [15:0] CRC16_POLY     = 16'hA001;
	localparam logic [15:0] CRC16_RESIDUAL = 16'hB001;

endpackage

// File: src/usb_sie_top.sv
// Top level of the USB serial interface engine, between transceiver and processor I/O bus
`timescale 1ns/1ps

module usb_sie_top import usb_sie_pkg::*; #(
	parameter int FIFO_DEPTH = 64,
	parameter int MAX_PACKET = 8
)
(
	input  logic        clk,
	input  logic        arst_n,
	input  usb_rx_t     rx,
	input  logic        tx_ready,
	input  io_addr_t    io_addr,
	input  logic        io_rd,
	input  logic        io_wr,
	input  logic [15:0] io_dout,
	output usb_tx_t     tx,
	output logic [15:0] io_din
);

	logic [3:0]  endp;
	logic        in_rdreq;
	logic        out_wrreq;
	logic [7:0]  out_data;
	logic        stall_sent;
	logic        sel_empty;
	logic        sel_full;
	logic        sel_stall;
	logic [7:0]  sel_q;
	logic [15:0] crc;
	logic        crc_ok;
	logic        crc_clear;
	logic        crc_step;
	logic [7:0]  crc_byte;
	logic        len_clear;
	logic        len_step;
	logic        len_max;

	usb_packet_fsm i_fsm (
		.clk(clk), .arst_n(arst_n), .rx(rx), .tx_ready(tx_ready),
		.sel_empty(sel_empty), .sel_full(sel_full), .sel_stall(sel_stall), .sel_q(sel_q),
		.crc(crc), .crc_ok(crc_ok), .len_max(len_max), .tx(tx), .endp(endp),
		.in_rdreq(in_rdreq), .out_wrreq(out_wrreq), .out_data(out_data),
		.stall_sent(stall_sent), .crc_clear(crc_clear), .crc_step(crc_step),
		.crc_byte(crc_byte), .len_clear(len_clear), .len_step(len_step));

	usb_crc16 i_crc16 (
		.clk(clk), .arst_n(arst_n), .clear(crc_clear), .step(crc_step),
		.data(crc_byte), .crc(crc), .ok(crc_ok));

	usb_packet_len #(.MAX_PACKET(MAX_PACKET)) i_len (
		.clk(clk), .arst_n(arst_n), .clear(len_clear), .step(len_step), .len_max(len_max));

	usb_endpoint_regs #(.FIFO_DEPTH(FIFO_DEPTH)) i_regs (
		.clk(clk), .arst_n(arst_n), .usb_reset(rx.usb_reset), .endp(endp),
		.in_rdreq(in_rdreq), .out_wrreq(out_wrreq), .out_data(out_data),
		.stall_sent(stall_sent), .io_addr(io_addr), .io_rd(io_rd), .io_wr(io_wr),
		.io_dout(io_dout), .io_din(io_din), .sel_empty(sel_empty), .sel_full(sel_full),
		.sel_stall(sel_stall), .sel_q(sel_q));

endmodule

// File: verilog.f
src/usb_sie_pkg.sv
src/usb_crc16.sv
src/usb_packet_len.sv
src/usb_endpoint_fifo.sv
src/usb_endpoint_regs.sv
src/usb_packet_fsm.sv
src/usb_sie_top.sv
dv/tb_clock.sv
dv/tb_usb_sie.sv
